// ==== verif/lcd_ctrl_stim.txt ====
# record header: op level lines (op 0 boot, 2 pear, 3 heart, 4 bars)
# stream line: dc byte(hex) repeat
0 0 5
0 21 1
0 90 1
0 20 1
0 0C 1
1 00 504
2 0 9
0 80 1
0 40 1
1 30 1
1 48 1
1 84 1
1 82 1
1 87 1
1 49 1
1 30 1
3 0 11
0 B8 1
0 40 1
1 0C 1
1 12 1
1 21 1
1 41 1
1 82 1
1 41 1
1 21 1
1 12 1
1 0C 1
4 0 3
0 89 1
0 40 1
1 00 14
4 1 4
0 89 1
0 40 1
1 7E 2
1 00 12
4 2 6
0 89 1
0 40 1
1 7E 2
1 00 1
1 7E 2
1 00 9
4 3 8
0 89 1
0 40 1
1 7E 2
1 00 1
1 7E 2
1 00 1
1 7E 2
1 00 6
4 4 10
0 89 1
0 40 1
1 7E 2
1 00 1
1 7E 2
1 00 1
1 7E 2
1 00 1
1 7E 2
1 00 3
4 7 10
0 89 1
0 40 1
1 7E 2
1 00 1
1 7E 2
1 00 1
1 7E 2
1 00 1
1 7E 2
1 00 3
4 15 10
0 89 1
0 40 1
1 7E 2
1 00 1
1 7E 2
1 00 1
1 7E 2
1 00 1
1 7E 2
1 00 3

// ==== lcd_ctrl_top.f ====
+incdir+design
design/lcd_pkg.sv
design/sprite_rom.sv
design/spi_serializer.sv
design/byte_generator.sv
design/frame_sequencer.sv
design/lcd_ctrl_top.sv
verif/tb_clock_gen.sv
verif/lcd_ctrl_tb.sv

// ==== verif/lcd_ctrl_tb.sv ====
`default_nettype none

module lcd_ctrl_tb;
	import lcd_pkg::*;

	logic       clock;
	logic       rst;
	logic       req;
	lcd_op_e    req_op;
	logic [3:0] req_level;
	logic       ready;
	logic       lcd_rst_n;
	logic       sce;
	logic       sclk;
	logic       mosi;
	logic       dc;

	int rec_op[$];
	int rec_level[$];
	int rec_first[$]; // first stream line of each record
	int rec_lines[$];
	int line_dc[$];
	int line_byte[$];
	int line_cnt[$];

	logic [8:0] rx_q[$]; // {dc, data} as seen on the line
	logic [7:0] rx_shift;
	logic       rx_dc;
	int         rx_bits = 8;
	int         errors = 0;
	int         tests = 0;
	int         failed_tests = 0;
	bit         aborted = 1'b0;
	integer     seed = 32'h47ee_db60;

	tb_clock_gen u_clock_gen (.clock(clock));

	lcd_ctrl_top DUT (
		.clock     (clock),
		.rst       (rst),
		.req       (req),
		.req_op    (req_op),
		.req_level (req_level),
		.ready     (ready),
		.lcd_rst_n (lcd_rst_n),
		.sce       (sce),
		.sclk      (sclk),
		.mosi      (mosi),
		.dc        (dc)
	);

	always @(negedge sce) rx_bits = 0;

	always @(negedge clock) begin
		if (sce === 1'b1 && sclk !== 1'b0) begin
			$display("Framing failure at %0t: sclk was high while sce was high", $time);
			errors++;
		end
	end

	always @(posedge sclk) begin
		if (sce) begin
			$display("Framing failure at %0t: sclk rose while sce was high", $time);
			errors++;
		end else begin
			if (rx_bits == 0) begin
				rx_dc = dc;
			end else if (dc !== rx_dc) begin
				$display("Error at %0t: dc changed inside a byte", $time);
				errors++;
			end
			rx_shift = {rx_shift[6:0], mosi}; // msb first
			rx_bits++;
			if (rx_bits == 8)
				rx_q.push_back({rx_dc, rx_shift});
		end
	end

	always @(posedge sce) begin
		if (rx_bits != 8) begin
			$display("Framing failure at %0t: sce rose after %0d sclk rises", $time, rx_bits);
			errors++;
		end
	end

	task automatic next_cycle();
		@(posedge clock);
		#5;
	endtask

	task automatic wait_ready(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (ready !== level && n < limit) begin
			next_cycle();
			n++;
		end
		if (ready !== level) begin
			$display("Timeout: ready did not reach %0b within %0d cycles in %s",
				level, limit, what);
			aborted = 1'b1;
		end
	endtask

	task automatic load_stim();
		int    fd;
		int    a;
		int    b;
		int    c;
		int    pending;
		string line;
		fd = $fopen("verif/lcd_ctrl_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file verif/lcd_ctrl_stim.txt");
			aborted = 1'b1;
			return;
		end
		pending = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 5 || line[0] == "#")
				continue;
			if (pending == 0) begin
				if ($sscanf(line, "%d %d %d", a, b, c) == 3) begin // record header
					rec_op.push_back(a);
					rec_level.push_back(b);
					rec_first.push_back(line_dc.size());
					rec_lines.push_back(c);
					pending = c;
				end
			end else if ($sscanf(line, "%d %h %d", a, b, c) == 3) begin
				line_dc.push_back(a);
				line_byte.push_back(b);
				line_cnt.push_back(c);
				pending--;
			end
		end
		$fclose(fd);
	endtask

	task automatic check_stream(input int r, input string name);
		logic [8:0] exp_q[$];
		int         mism;
		mism = 0;
		for (int l = rec_first[r]; l < rec_first[r] + rec_lines[r]; l++)
			repeat (line_cnt[l]) exp_q.push_back({line_dc[l][0], line_byte[l][7:0]});
		if (rx_q.size() != exp_q.size()) begin
			$display("Error at %0t: %s sent %0d bytes, expected %0d", $time, name,
				rx_q.size(), exp_q.size());
			errors++;
		end
		for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
			if (rx_q[i] !== exp_q[i]) begin
				if (mism < 4)
					$display("Error at %0t: %s byte %0d is dc=%0b 0x%02h, expected dc=%0b 0x%02h",
						$time, name, i, rx_q[i][8], rx_q[i][7:0], exp_q[i][8], exp_q[i][7:0]);
				mism++;
			end
		end
		errors += mism;
		rx_q.delete();
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before && !aborted) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic run_boot(input int r);
		int e0;
		int n;
		e0 = errors;
		n = 0;
		@(negedge clock);
		while (lcd_rst_n !== 1'b1 && n < 100) begin
			n++;
			@(negedge clock);
		end
		if (n != 16) begin
			$display("Error at %0t: lcd_rst_n low for %0d clocks, expected 16", $time, n);
			errors++;
		end
		next_cycle();
		wait_ready(1'b1, 50000, "boot");
		if (!aborted)
			check_stream(r, "boot");
		report_test("boot", e0);
	endtask

	task automatic run_draw(input int r, input string name, input bit busy);
		int e0;
		if (aborted)
			return;
		e0 = errors;
		req       = 1'b1;
		req_op    = lcd_op_e'(rec_op[r]);
		req_level = rec_level[r][3:0];
		next_cycle();
		req = 1'b0;
		wait_ready(1'b0, 4, name);
		if (busy) begin
			repeat (3) begin // strobes while ready is low
				next_cycle();
				req       = 1'b1;
				req_op    = op_bars;
				req_level = 4'd2;
				next_cycle();
				req = 1'b0;
			end
		end
		if (!aborted)
			wait_ready(1'b1, 5000, name);
		if (busy && !aborted) begin
			repeat (200) next_cycle(); // nothing more may appear
			if (ready !== 1'b1) begin
				$display("Error at %0t: ready fell without a request", $time);
				errors++;
			end
		end
		if (!aborted)
			check_stream(r, name);
		report_test(name, e0);
	endtask

	initial begin
		int bar_idx[$];
		int pear_r;
		int heart_r;
		int j;
		int t;
		rst       = 1'b1;
		req       = 1'b0;
		req_op    = op_pear;
		req_level = 4'd0;
		pear_r    = 0;
		heart_r   = 0;
		load_stim();
		repeat (8) @(posedge clock);
		#5;
		rst = 1'b0;
		if (!aborted && rec_op.size() > 0)
			run_boot(0);
		for (int r = 0; r < rec_op.size(); r++) begin
			if (rec_op[r] == 2)
				pear_r = r;
			if (rec_op[r] == 3)
				heart_r = r;
			if (rec_op[r] == 4)
				bar_idx.push_back(r);
		end
		for (int i = bar_idx.size() - 1; i > 0; i--) begin
			j = $unsigned($random(seed)) % (i + 1);
			t = bar_idx[i];
			bar_idx[i] = bar_idx[j];
			bar_idx[j] = t;
		end
		run_draw(pear_r, "pear", 1'b0);
		run_draw(heart_r, "heart", 1'b0);
		foreach (bar_idx[i])
			run_draw(bar_idx[i], $sformatf("bars level %0d", rec_level[bar_idx[i]]), 1'b0);
		run_draw(pear_r, "strobes while busy", 1'b1);
		run_draw(heart_r, "heart after busy", 1'b0);
		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (aborted || errors != 0 || tests == 0)
			$display("Simulation finished: FAIL");
		else
			$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
	output logic clock
);

	initial clock = 1'b0;

	always #20 clock = ~clock; // 40 unit period

endmodule

`default_nettype wire

// ==== design/lcd_ctrl_top.sv ====
`default_nettype none

module lcd_ctrl_top (
	input  wire logic             clock,
	input  wire logic             rst,
	input  wire logic             req,
	input  wire lcd_pkg::lcd_op_e req_op,
	input  wire logic [3:0]       req_level,
	output      logic             ready,
	output      logic             lcd_rst_n,
	output      logic             sce,
	output      logic             sclk,
	output      logic             mosi,
	output      logic             dc
);
	import lcd_pkg::*;

	lcd_job_t  job;
	lcd_byte_t gen_byte;
	logic      job_start;
	logic      job_done;
	logic      byte_valid;
	logic      byte_taken;
	logic      line_idle;

	frame_sequencer u_frame_sequencer (
		.clock     (clock),
		.rst       (rst),
		.req       (req),
		.req_op    (req_op),
		.req_level (req_level),
		.ready     (ready),
		.lcd_rst_n (lcd_rst_n),
		.job       (job),
		.job_start (job_start),
		.job_done  (job_done),
		.line_idle (line_idle)
	);

	byte_generator u_byte_generator (
		.clock      (clock),
		.rst        (rst),
		.job        (job),
		.job_start  (job_start),
		.job_done   (job_done),
		.out_byte   (gen_byte),
		.byte_valid (byte_valid),
		.byte_taken (byte_taken)
	);

	spi_serializer u_spi_serializer (
		.clock      (clock),
		.rst        (rst),
		.in_byte    (gen_byte),
		.byte_valid (byte_valid),
		.byte_taken (byte_taken),
		.line_idle  (line_idle),
		.sce        (sce),
		.sclk       (sclk),
		.mosi       (mosi),
		.dc         (dc)
	);

endmodule

`default_nettype wire

// ==== design/frame_sequencer.sv ====
`default_nettype none

`include "lcd_macros.svh"

module frame_sequencer (
	input  wire                logic clock,
	input  wire                logic rst,
	input  wire                logic req,
	input  wire lcd_pkg::lcd_op_e    req_op,
	input  wire                logic [3:0] req_level,
	output                     logic ready,
	output                     logic lcd_rst_n,
	output lcd_pkg::lcd_job_t        job,
	output                     logic job_start,
	input  wire                logic job_done,
	input  wire                logic line_idle
);
	import lcd_pkg::*;

	seq_state_e state;
	logic [7:0] rst_cnt;
	logic [2:0] sat_level;

	assign sat_level = (req_level > 4'(`LCD_BAR_MAX_LEVEL)) ?
		3'(`LCD_BAR_MAX_LEVEL) : req_level[2:0];

	assign ready = (state == st_idle); // drops the cycle after a request is taken

	always_ff @(posedge clock) begin
		job_start <= 1'b0;
		if (rst) begin
			state     <= st_reset;
			rst_cnt   <= 8'd0;
			lcd_rst_n <= 1'b0;
			job       <= '0;
		end else begin
			case (state)
				st_reset: begin
					if (rst_cnt == 8'(`LCD_RST_CYCLES - 1)) begin
						lcd_rst_n <= 1'b1;
						job.op    <= op_init;
						job.level <= 3'd0;
						job_start <= 1'b1;
						state     <= st_init;
					end else begin
						rst_cnt <= rst_cnt + 8'd1;
					end
				end
				st_init: begin
					if (job_done) begin // clear can follow without waiting for the line
						job.op    <= op_clear;
						job_start <= 1'b1;
						state     <= st_clear;
					end
				end
				st_clear: begin
					if (job_done)
						state <= st_drain;
				end
				st_busy: begin
					if (job_done)
						state <= st_drain;
				end
				st_drain: begin
					if (line_idle) // last byte fully shifted
						state <= st_idle;
				end
				st_idle: begin
					if (req) begin
						job.op    <= req_op;
						job.level <= sat_level;
						job_start <= 1'b1;
						state     <= st_busy;
					end
				end
				default: state <= st_reset;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/byte_generator.sv ====
`default_nettype none

`include "lcd_macros.svh"

module byte_generator (
	input  wire                logic clock,
	input  wire                logic rst,
	input  wire lcd_pkg::lcd_job_t   job,
	input  wire                logic job_start,
	output                     logic job_done,
	output lcd_pkg::lcd_byte_t       out_byte,
	output                     logic byte_valid,
	input  wire                logic byte_taken
);
	import lcd_pkg::*;

	gen_phase_e phase;
	lcd_job_t   cur_job;
	logic [8:0] count;     // byte index inside the current phase
	logic [1:0] bar_pos;   // 0,1 fill and 2 gap
	logic [2:0] bar_units; // level units still to draw
	logic [7:0] rom_pattern;
	logic       rom_last;
	logic       last_byte;

	sprite_rom u_sprite_rom (
		.op          (cur_job.op),
		.column      (count[3:0]),
		.pattern     (rom_pattern),
		.last_column (rom_last)
	);

	assign byte_valid = (phase != ph_idle);

	always_comb begin
		out_byte.dc   = 1'b0;
		out_byte.data = 8'h00;
		last_byte     = 1'b0;
		case (phase)
			ph_init: begin
				case (count[1:0])
					2'd0: out_byte.data = `LCD_INIT_0;
					2'd1: out_byte.data = `LCD_INIT_1;
					2'd2: out_byte.data = `LCD_INIT_2;
					default: out_byte.data = `LCD_INIT_3;
				endcase
				last_byte = (count == 9'd3);
			end
			ph_clear: begin
				out_byte.dc = 1'b1;
				last_byte   = (count == 9'(`LCD_CLEAR_BYTES - 1));
			end
			ph_addr_x: begin
				case (cur_job.op)
					op_pear:  out_byte.data = `LCD_PEAR_X;
					op_heart: out_byte.data = `LCD_HEART_X;
					default:  out_byte.data = `LCD_BAR_X;
				endcase
			end
			ph_addr_y: out_byte.data = `LCD_ROW0_Y;
			ph_sprite: begin
				out_byte.dc   = 1'b1;
				out_byte.data = rom_pattern;
				last_byte     = rom_last;
			end
			ph_bar: begin
				out_byte.dc = 1'b1;
				if (bar_units != 3'd0 && bar_pos != 2'd2)
					out_byte.data = `LCD_BAR_FILL;
				last_byte = (count == 9'(`LCD_BAR_COLUMNS - 1));
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		job_done <= 1'b0;
		if (rst) begin
			phase     <= ph_idle;
			cur_job   <= '0;
			count     <= 9'd0;
			bar_pos   <= 2'd0;
			bar_units <= 3'd0;
		end else begin
			case (phase)
				ph_idle: begin
					if (job_start) begin
						cur_job   <= job;
						count     <= 9'd0;
						bar_pos   <= 2'd0;
						bar_units <= job.level;
						case (job.op)
							op_init:  phase <= ph_init;
							op_clear: phase <= ph_clear;
							default:  phase <= ph_addr_x;
						endcase
					end
				end
				ph_addr_x: begin
					if (byte_taken)
						phase <= ph_addr_y;
				end
				ph_addr_y: begin
					if (byte_taken)
						phase <= (cur_job.op == op_bars) ? ph_bar : ph_sprite;
				end
				default: begin
					if (byte_taken) begin
						count <= count + 9'd1;
						if (bar_pos == 2'd2) begin
							bar_pos <= 2'd0;
							if (bar_units != 3'd0)
								bar_units <= bar_units - 3'd1;
						end else begin
							bar_pos <= bar_pos + 2'd1;
						end
						if (last_byte) begin
							phase    <= ph_idle;
							job_done <= 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/spi_serializer.sv ====
`default_nettype none

`include "lcd_macros.svh"

module spi_serializer (
	input  wire                 logic clock,
	input  wire                 logic rst,
	input  wire lcd_pkg::lcd_byte_t   in_byte,
	input  wire                 logic byte_valid,
	output                      logic byte_taken,
	output                      logic line_idle,
	output                      logic sce,
	output                      logic sclk,
	output                      logic mosi,
	output                      logic dc
);
	import lcd_pkg::*;

	logic [7:0] div_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift_reg;
	logic       gap;       // sce high spacing between bytes
	logic       half_tick;
	logic       fall_tick;
	logic       load;

	assign half_tick = (div_cnt == 8'(`LCD_SPI_DIV - 1));
	assign fall_tick = ~sce & half_tick & sclk;
	assign line_idle = sce & ~gap;
	assign load      = line_idle & byte_valid;
	assign mosi      = shift_reg[7]; // msb first

	always_ff @(posedge clock) begin
		byte_taken <= 1'b0;
		if (rst) begin
			sce     <= 1'b1;
			sclk    <= 1'b0;
			gap     <= 1'b0;
			div_cnt <= 8'd0;
			bit_cnt <= 3'd0;
		end else if (gap) begin
			if (half_tick) begin
				gap     <= 1'b0;
				div_cnt <= 8'd0;
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
		end else if (!sce) begin
			if (half_tick) begin
				div_cnt <= 8'd0;
				sclk    <= ~sclk;
				if (sclk) begin
					if (bit_cnt == 3'd7) begin // eighth falling edge ends the frame
						sce <= 1'b1;
						gap <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 3'd1;
					end
				end
			end else begin
				div_cnt <= div_cnt + 8'd1;
			end
		end else if (load) begin
			sce        <= 1'b0;
			byte_taken <= 1'b1;
			div_cnt    <= 8'd0;
			bit_cnt    <= 3'd0;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			shift_reg <= in_byte.data;
			dc        <= in_byte.dc; // steady for the whole byte
		end else if (fall_tick && bit_cnt != 3'd7) begin
			shift_reg <= {shift_reg[6:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== design/sprite_rom.sv ====
`default_nettype none

module sprite_rom (
	input  wire lcd_pkg::lcd_op_e op,
	input  wire logic [3:0]       column,
	output      logic [7:0]       pattern,
	output      logic             last_column
);
	import lcd_pkg::*;

	always_comb begin
		pattern     = 8'h00;
		last_column = 1'b1; // nothing to draw for other ops
		case (op)
			op_pear: begin
				case (column)
					4'd0: pattern = 8'h30;
					4'd1: pattern = 8'h48;
					4'd2: pattern = 8'h84;
					4'd3: pattern = 8'h82;
					4'd4: pattern = 8'h87;
					4'd5: pattern = 8'h49;
					default: pattern = 8'h30;
				endcase
				last_column = (column >= 4'd6);
			end
			op_heart: begin
				case (column)
					4'd0, 4'd8: pattern = 8'h0C; // symmetric shape
					4'd1, 4'd7: pattern = 8'h12;
					4'd2, 4'd6: pattern = 8'h21;
					4'd3, 4'd5: pattern = 8'h41;
					4'd4:       pattern = 8'h82;
					default:    pattern = 8'h0C;
				endcase
				last_column = (column >= 4'd8);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	typedef enum logic [2:0] {
		op_init  = 3'd0,
		op_clear = 3'd1,
		op_pear  = 3'd2,
		op_heart = 3'd3,
		op_bars  = 3'd4
	} lcd_op_e;

	typedef struct packed {
		lcd_op_e    op;
		logic [2:0] level; // already saturated
	} lcd_job_t;

	typedef struct packed {
		logic       dc; // 1 = data, 0 = command
		logic [7:0] data;
	} lcd_byte_t;

	typedef enum logic [2:0] {
		st_reset, st_init, st_clear, st_busy, st_drain, st_idle
	} seq_state_e;

	typedef enum logic [2:0] {
		ph_idle, ph_init, ph_clear, ph_addr_x, ph_addr_y, ph_sprite, ph_bar
	} gen_phase_e;

endpackage

`default_nettype wire

// ==== design/lcd_macros.svh ====
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

`define LCD_SPI_DIV        4     // clocks per half sclk period
`define LCD_RST_CYCLES     16
`define LCD_CLEAR_BYTES    504   // 84 x 6 banks
`define LCD_BAR_COLUMNS    14
`define LCD_BAR_MAX_LEVEL  4
`define LCD_BAR_FILL       8'h7E

`define LCD_INIT_0         8'h21 // extended instruction set
`define LCD_INIT_1         8'h90 // vop contrast
`define LCD_INIT_2         8'h20 // back to basic set
`define LCD_INIT_3         8'h0C // normal display

`define LCD_PEAR_X         8'h80
`define LCD_HEART_X        8'hB8
`define LCD_BAR_X          8'h89
`define LCD_ROW0_Y         8'h40

`endif
